//--- compile.f
rtl/gat_types_pkg.sv
rtl/gat_ctrl_pkg.sv
rtl/node_info_decoder.sv
rtl/num_node_controller.sv
rtl/num_node_bram.sv
rtl/num_node_axil_reader.sv
rtl/gat_num_node_top.sv
tests/num_node_checker.sv
tests/num_node_properties.sv
tests/tb_gat_num_node.sv

//--- tests/tb_gat_num_node.sv
/*
 * Testbench for the GAT subgraph node-count path
 * Streams random subgraphs, reads status and table over AXI4-Lite
 * and keeps the reference model that the checker compares against
 */
`timescale 1ns/1ns

module tb_gat_num_node;
  import gat_types_pkg::*;
  import gat_ctrl_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic                       clk;
  logic                       rst_n;
  logic                       node_info_valid;
  logic [NODE_INFO_WIDTH-1:0] node_info_data;
  logic                       node_info_ready;
  logic                       s_awvalid;
  logic                       s_awready;
  logic [11:0]                s_awaddr;
  logic                       s_wvalid;
  logic                       s_wready;
  logic [31:0]                s_wdata;
  logic                       s_bvalid;
  logic                       s_bready;
  logic [1:0]                 s_bresp;
  logic                       s_arvalid;
  logic                       s_arready;
  logic [11:0]                s_araddr;
  logic                       s_rvalid;
  logic                       s_rready;
  logic [31:0]                s_rdata;
  logic [1:0]                 s_rresp;

  int seed = 20;
  int timeouts = 0;
  int tests_run = 0;
  int last_errors = 0;
  int last_checks = 0;
  int check_count;
  int error_count;

  // ====================
  // Reference model
  // ====================
  int   model_count;
  logic model_mismatch;
  int   model_size [NUM_SUBGRAPHS];
  logic open_sub;
  int   open_announced;
  int   open_words;

  gat_num_node_top i_gat_num_node_top (
    .clk (clk), .rst_n (rst_n),
    .node_info_valid (node_info_valid), .node_info_data (node_info_data),
    .node_info_ready (node_info_ready),
    .s_awvalid (s_awvalid), .s_awready (s_awready), .s_awaddr (s_awaddr),
    .s_wvalid (s_wvalid), .s_wready (s_wready), .s_wdata (s_wdata),
    .s_bvalid (s_bvalid), .s_bready (s_bready), .s_bresp (s_bresp),
    .s_arvalid (s_arvalid), .s_arready (s_arready), .s_araddr (s_araddr),
    .s_rvalid (s_rvalid), .s_rready (s_rready), .s_rdata (s_rdata), .s_rresp (s_rresp)
  );

  num_node_checker i_num_node_checker (
    .clk (clk), .rst_n (rst_n),
    .s_arvalid (s_arvalid), .s_arready (s_arready), .s_araddr (s_araddr),
    .s_rvalid (s_rvalid), .s_rready (s_rready), .s_rdata (s_rdata), .s_rresp (s_rresp),
    .s_awvalid (s_awvalid), .s_awready (s_awready), .s_awaddr (s_awaddr),
    .s_bvalid (s_bvalid), .s_bready (s_bready), .s_bresp (s_bresp),
    .check_count (check_count), .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int rand_range(input int lo, input int hi);
    int rnd;
    rnd = $random(seed);
    return lo + ((rnd & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  // Failures flagged by the bound assertions
  function automatic int assertion_failures();
    return i_gat_num_node_top.i_num_node_controller.i_ctrl_properties.fail_count
         + i_gat_num_node_top.i_num_node_axil_reader.i_axil_properties.fail_count;
  endfunction

  function automatic void model_clear();
    model_count    = 0;
    model_mismatch = 1'b0;
    open_sub       = 1'b0;
  endfunction

  // A subgraph is checked only when the next source word shows up
  function automatic void model_add(input int announced, input int words);
    if (open_sub && open_words != open_announced) begin
      model_mismatch = 1'b1;
    end
    if (model_count < NUM_SUBGRAPHS) begin
      model_size[model_count] = announced;
      model_count             = model_count + 1;
    end
    open_sub       = 1'b1;
    open_announced = announced;
    open_words     = words;
  endfunction

  // Expected {resp, data} for a read at addr
  function automatic logic [33:0] expected_read(input logic [11:0] addr);
    logic [31:0] data;
    logic [1:0]  resp;
    int          idx;
    data = '0;
    resp = SLVERR;
    if (addr == 12'h000) begin
      data[0]    = model_mismatch;
      data[14:8] = 7'(model_count);
      resp       = OKAY;
    end else if (addr >= 12'h100 && addr <= 12'h1fc && addr[1:0] == 2'b00) begin
      idx = (int'(addr) - 'h100) / 4;
      if (idx < model_count) begin
        data = 32'(model_size[idx]);
        resp = OKAY;
      end
    end
    return {resp, data};
  endfunction

  function automatic logic [1:0] expected_bresp(input logic [11:0] addr);
    return (addr == 12'h004) ? OKAY : SLVERR;
  endfunction

  // ====================
  // Bus drivers
  // ====================
  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    timeouts = timeouts + 1;
  endtask

  task automatic send_word(input logic src, input int announced);
    int waited;
    waited = 0;
    if (rand_range(0, 3) == 0) begin
      repeat (rand_range(1, 3)) @(negedge clk);
    end
    node_info_valid = 1'b1;
    node_info_data  = {ROW_LEN_WIDTH'(rand_range(0, 2047)), NUM_NODE_WIDTH'(announced), src};
    while (!node_info_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (!node_info_ready) begin
      report_timeout("node_info_ready");
    end else begin
      @(negedge clk);
    end
    node_info_valid = 1'b0;
  endtask

  task automatic send_subgraph(input int announced, input int words);
    int i;
    model_add(announced, words);
    send_word(1'b1, announced);
    for (i = 1; i < words; i++) begin
      send_word(1'b0, announced);
    end
  endtask

  task automatic send_random_stream(input int num);
    int i;
    int n;
    for (i = 0; i < num; i++) begin
      n = rand_range(1, MAX_NODES);
      send_subgraph(n, n);
    end
    // Table write lands two cycles after the source word
    repeat (4) @(negedge clk);
  endtask

  task automatic read_reg(input logic [11:0] addr, input int hold);
    int waited;
    waited    = 0;
    s_arvalid = 1'b1;
    s_araddr  = addr;
    while (!s_arready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (!s_arready) begin
      report_timeout("s_arready");
      s_arvalid = 1'b0;
    end else begin
      @(negedge clk);
      s_arvalid = 1'b0;
      waited    = 0;
      while (!s_rvalid && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited = waited + 1;
      end
      if (!s_rvalid) begin
        report_timeout("s_rvalid");
      end else begin
        repeat (hold) @(negedge clk);
        s_rready = 1'b1;
        @(negedge clk);
        s_rready = 1'b0;
      end
    end
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    int   waited;
    logic aw_take;
    logic w_take;
    waited    = 0;
    s_awvalid = 1'b1;
    s_awaddr  = addr;
    s_wvalid  = 1'b1;
    s_wdata   = data;
    s_bready  = 1'b1;
    while ((s_awvalid || s_wvalid) && waited < WAIT_LIMIT) begin
      aw_take = s_awvalid && s_awready;
      w_take  = s_wvalid && s_wready;
      @(negedge clk);
      waited = waited + 1;
      if (aw_take) s_awvalid = 1'b0;
      if (w_take) s_wvalid = 1'b0;
    end
    if (s_awvalid || s_wvalid) begin
      report_timeout("write address or data handshake");
      s_awvalid = 1'b0;
      s_wvalid  = 1'b0;
    end else begin
      waited = 0;
      while (!s_bvalid && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited = waited + 1;
      end
      if (!s_bvalid) begin
        report_timeout("s_bvalid");
      end else begin
        @(negedge clk);
      end
    end
    s_bready = 1'b0;
  endtask

  // Status, every stored entry, and entries past the count
  task automatic read_all(input int hold_max);
    int i;
    read_reg(12'h000, rand_range(0, hold_max));
    for (i = 0; i < model_count; i++) begin
      read_reg(12'h100 + 12'(4 * i), rand_range(0, hold_max));
    end
    if (model_count < NUM_SUBGRAPHS) begin
      read_reg(12'h100 + 12'(4 * model_count), rand_range(0, hold_max));
    end
    read_reg(12'h1fc, rand_range(0, hold_max));
    read_reg(12'h008, rand_range(0, hold_max));
  endtask

  task automatic end_test(input string name);
    int errs;
    int checks;
    errs   = error_count + timeouts + assertion_failures() - last_errors;
    checks = check_count - last_checks;
    $display("test %-12s checks=%0d errors=%0d", name, checks, errs);
    last_errors = error_count + timeouts + assertion_failures();
    last_checks = check_count;
    tests_run   = tests_run + 1;
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    int i;
    int n;
    rst_n           = 1'b0;
    node_info_valid = 1'b0;
    node_info_data  = '0;
    s_awvalid       = 1'b0;
    s_awaddr        = '0;
    s_wvalid        = 1'b0;
    s_wdata         = '0;
    s_bready        = 1'b0;
    s_arvalid       = 1'b0;
    s_araddr        = '0;
    s_rready        = 1'b0;
    model_clear();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    send_random_stream(rand_range(1, 40));
    read_all(3);
    end_test("stream");

    // Announced count one short of the words sent
    n = rand_range(1, MAX_NODES - 1);
    send_subgraph(n, n + 1);
    send_random_stream(2);
    read_all(2);
    end_test("mismatch");

    write_reg(12'h004, 32'h1);
    model_clear();
    read_reg(12'h000, 0);
    write_reg(12'h008, 32'h1);
    write_reg(12'h000, 32'h1);
    send_random_stream(5);
    read_all(2);
    end_test("clear");

    for (i = 0; i < 16; i++) begin
      read_reg(12'h100 + 12'(4 * rand_range(0, model_count)), rand_range(1, 10));
    end
    read_reg(12'h000, rand_range(1, 10));
    end_test("backpressure");

    write_reg(12'h004, 32'h1);
    model_clear();
    send_random_stream(NUM_SUBGRAPHS + 6);
    read_all(1);
    end_test("saturate");

    $display("summary: tests=%0d checks=%0d errors=%0d timeouts=%0d asserts=%0d",
             tests_run, check_count, error_count, timeouts, assertion_failures());
    if (error_count == 0 && timeouts == 0 && assertion_failures() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tests/num_node_properties.sv
/*
 * Controller and AXI4-Lite read-channel assertions
 * Bound into the controller and into the AXI slave
 */
`timescale 1ns/1ns

module num_node_properties (
  input logic        clk,
  input logic        rst_n,
  input logic        spmm_vld,
  input logic        src_flag,
  input logic        bram_ena,
  input logic        s_arvalid,
  input logic        s_arready,
  input logic        s_rvalid,
  input logic        s_rready,
  input logic [31:0] s_rdata,
  input logic [1:0]  s_rresp
);
  int fail_count = 0;

  // Table writes come only from RUN, which a source word opens
  ena_only_in_run: assert property (
    @(posedge clk) disable iff (!rst_n) bram_ena |-> $past(spmm_vld && src_flag)
  ) else begin
    $error("table write enable outside RUN");
    fail_count++;
  end

  rvalid_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp)
  ) else begin
    $error("read response changed before RREADY");
    fail_count++;
  end

  // RAM stage, then response stage
  rvalid_after_ar: assert property (
    @(posedge clk) disable iff (!rst_n)
    s_arvalid && s_arready |=> !s_rvalid ##1 s_rvalid
  ) else begin
    $error("RVALID not two cycles after the AR handshake");
    fail_count++;
  end

endmodule

bind num_node_controller num_node_properties i_ctrl_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .spmm_vld   (spmm_vld),
  .src_flag   (src_flag),
  .bram_ena   (num_node_bram_ena),
  .s_arvalid  (1'b0),
  .s_arready  (1'b0),
  .s_rvalid   (1'b0),
  .s_rready   (1'b0),
  .s_rdata    (32'h0),
  .s_rresp    (2'b00)
);

bind num_node_axil_reader num_node_properties i_axil_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .spmm_vld   (1'b0),
  .src_flag   (1'b0),
  .bram_ena   (1'b0),
  .s_arvalid  (s_arvalid),
  .s_arready  (s_arready),
  .s_rvalid   (s_rvalid),
  .s_rready   (s_rready),
  .s_rdata    (s_rdata),
  .s_rresp    (s_rresp)
);

//--- tests/num_node_checker.sv
/*
 * Response checker for the node-count AXI4-Lite slave
 * Compares every R and B handshake with the testbench model
 * and checks that a stalled read response holds its value
 */
`timescale 1ns/1ns

module num_node_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        s_arvalid,
  input  logic        s_arready,
  input  logic [11:0] s_araddr,
  input  logic        s_rvalid,
  input  logic        s_rready,
  input  logic [31:0] s_rdata,
  input  logic [1:0]  s_rresp,
  input  logic        s_awvalid,
  input  logic        s_awready,
  input  logic [11:0] s_awaddr,
  input  logic        s_bvalid,
  input  logic        s_bready,
  input  logic [1:0]  s_bresp,
  output int          check_count,
  output int          error_count
);
  logic [11:0] rd_addr_q;
  logic [11:0] wr_addr_q;
  logic        stall_q = 1'b0;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;
  logic [33:0] exp_word;
  logic [1:0]  exp_bresp;
  int          checks = 0;
  int          errors = 0;

  assign check_count = checks;
  assign error_count = errors;

  always @(posedge clk) begin
    if (rst_n) begin
      if (s_arvalid && s_arready) begin
        rd_addr_q <= s_araddr;
      end
      if (s_awvalid && s_awready) begin
        wr_addr_q <= s_awaddr;
      end

      // Response held back by the master must not move
      if (stall_q && s_rvalid) begin
        if (s_rdata !== rdata_q || s_rresp !== rresp_q) begin
          $display("error s_rdata stalled exp=%h/%h got=%h/%h",
                   rdata_q, rresp_q, s_rdata, s_rresp);
          errors = errors + 1;
        end
      end

      if (s_rvalid && s_rready) begin
        exp_word = tb_gat_num_node.expected_read(rd_addr_q);
        checks   = checks + 1;
        if (s_rdata !== exp_word[31:0]) begin
          $display("error rdata addr=%h exp=%h got=%h", rd_addr_q, exp_word[31:0], s_rdata);
          errors = errors + 1;
        end
        if (s_rresp !== exp_word[33:32]) begin
          $display("error rresp addr=%h exp=%h got=%h", rd_addr_q, exp_word[33:32], s_rresp);
          errors = errors + 1;
        end
      end

      if (s_bvalid && s_bready) begin
        exp_bresp = tb_gat_num_node.expected_bresp(wr_addr_q);
        checks    = checks + 1;
        if (s_bresp !== exp_bresp) begin
          $display("error bresp addr=%h exp=%h got=%h", wr_addr_q, exp_bresp, s_bresp);
          errors = errors + 1;
        end
      end

      stall_q <= s_rvalid && !s_rready;
      rdata_q <= s_rdata;
      rresp_q <= s_rresp;
    end
  end

endmodule

//--- rtl/gat_num_node_top.sv
/*
 * GAT subgraph node-count path
 * Decoder, controller, table RAM and AXI4-Lite slave
 */
`timescale 1ns/1ns

module gat_num_node_top (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       node_info_valid,
  input  logic [gat_types_pkg::NODE_INFO_WIDTH-1:0]  node_info_data,
  output logic                                       node_info_ready,
  input  logic                                       s_awvalid,
  output logic                                       s_awready,
  input  logic [gat_ctrl_pkg::AXI_ADDR_WIDTH-1:0]    s_awaddr,
  input  logic                                       s_wvalid,
  output logic                                       s_wready,
  input  logic [gat_ctrl_pkg::AXI_DATA_WIDTH-1:0]    s_wdata,
  output logic                                       s_bvalid,
  input  logic                                       s_bready,
  output logic [1:0]                                 s_bresp,
  input  logic                                       s_arvalid,
  output logic                                       s_arready,
  input  logic [gat_ctrl_pkg::AXI_ADDR_WIDTH-1:0]    s_araddr,
  output logic                                       s_rvalid,
  input  logic                                       s_rready,
  output logic [gat_ctrl_pkg::AXI_DATA_WIDTH-1:0]    s_rdata,
  output logic [1:0]                                 s_rresp
);
  import gat_types_pkg::*;

  // Decoder outputs
  logic                          spmm_vld;
  logic                          src_flag;
  logic [NUM_NODE_WIDTH-1:0]     num_node;
  logic                          count_mismatch;

  // Table write side
  logic [NUM_NODE_WIDTH-1:0]     num_node_bram_din;
  logic                          num_node_bram_ena;
  logic [NUM_NODE_ADDR_W-1:0]    num_node_bram_addra;
  logic [SUBGRAPH_CNT_WIDTH-1:0] subgraph_count;

  // Table read side
  logic                          bram_rd_en;
  logic [NUM_NODE_ADDR_W-1:0]    bram_rd_addr;
  logic [NUM_NODE_WIDTH-1:0]     bram_rd_data;
  logic                          clear;

  node_info_decoder i_node_info_decoder (
    .clk             (clk),
    .rst_n           (rst_n),
    .node_info_valid (node_info_valid),
    .node_info_data  (node_info_data),
    .node_info_ready (node_info_ready),
    .clear           (clear),
    .spmm_vld        (spmm_vld),
    .src_flag        (src_flag),
    .num_node        (num_node),
    .count_mismatch  (count_mismatch)
  );

  num_node_controller i_num_node_controller (
    .clk                 (clk),
    .rst_n               (rst_n),
    .spmm_vld            (spmm_vld),
    .src_flag            (src_flag),
    .num_node            (num_node),
    .clear               (clear),
    .num_node_bram_din   (num_node_bram_din),
    .num_node_bram_ena   (num_node_bram_ena),
    .num_node_bram_addra (num_node_bram_addra),
    .subgraph_count      (subgraph_count)
  );

  num_node_bram i_num_node_bram (
    .clk   (clk),
    .ena   (num_node_bram_ena),
    .addra (num_node_bram_addra),
    .dina  (num_node_bram_din),
    .enb   (bram_rd_en),
    .addrb (bram_rd_addr),
    .doutb (bram_rd_data)
  );

  num_node_axil_reader i_num_node_axil_reader (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_awvalid      (s_awvalid),
    .s_awready      (s_awready),
    .s_awaddr       (s_awaddr),
    .s_wvalid       (s_wvalid),
    .s_wready       (s_wready),
    .s_wdata        (s_wdata),
    .s_bvalid       (s_bvalid),
    .s_bready       (s_bready),
    .s_bresp        (s_bresp),
    .s_arvalid      (s_arvalid),
    .s_arready      (s_arready),
    .s_araddr       (s_araddr),
    .s_rvalid       (s_rvalid),
    .s_rready       (s_rready),
    .s_rdata        (s_rdata),
    .s_rresp        (s_rresp),
    .subgraph_count (subgraph_count),
    .count_mismatch (count_mismatch),
    .bram_rd_en     (bram_rd_en),
    .bram_rd_addr   (bram_rd_addr),
    .bram_rd_data   (bram_rd_data),
    .clear          (clear)
  );

endmodule

//--- rtl/num_node_axil_reader.sv
/*
 * AXI4-Lite slave for the node-count table
 * Serves status and stored counts through a two-stage read pipeline
 * and turns a write to the clear register into a clear pulse
 */
`timescale 1ns/1ns

module num_node_axil_reader (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          s_awvalid,
  output logic                                          s_awready,
  input  logic [gat_ctrl_pkg::AXI_ADDR_WIDTH-1:0]       s_awaddr,
  input  logic                                          s_wvalid,
  output logic                                          s_wready,
  input  logic [gat_ctrl_pkg::AXI_DATA_WIDTH-1:0]       s_wdata,
  output logic                                          s_bvalid,
  input  logic                                          s_bready,
  output logic [1:0]                                    s_bresp,
  input  logic                                          s_arvalid,
  output logic                                          s_arready,
  input  logic [gat_ctrl_pkg::AXI_ADDR_WIDTH-1:0]       s_araddr,
  output logic                                          s_rvalid,
  input  logic                                          s_rready,
  output logic [gat_ctrl_pkg::AXI_DATA_WIDTH-1:0]       s_rdata,
  output logic [1:0]                                    s_rresp,
  input  logic [gat_types_pkg::SUBGRAPH_CNT_WIDTH-1:0]  subgraph_count,
  input  logic                                          count_mismatch,
  output logic                                          bram_rd_en,
  output logic [gat_types_pkg::NUM_NODE_ADDR_W-1:0]     bram_rd_addr,
  input  logic [gat_types_pkg::NUM_NODE_WIDTH-1:0]      bram_rd_data,
  output logic                                          clear
);
  import gat_types_pkg::*;
  import gat_ctrl_pkg::*;

  logic                       ar_hs;
  logic                       rd_pend_q;
  reg_sel_e                   rd_sel_q;
  logic [NUM_NODE_ADDR_W-1:0] rd_idx_q;
  logic [AXI_DATA_WIDTH-1:0]  rdata_d;
  axi_resp_e                  rresp_d;
  axi_resp_e                  rresp_q;

  logic                       aw_hs;
  logic                       w_hs;
  logic                       aw_got_q;
  logic                       w_got_q;
  logic                       wr_fire;
  reg_sel_e                   aw_sel_q;
  reg_sel_e                   wr_sel;
  logic                       w_cmd_q;
  logic                       wr_cmd;
  axi_resp_e                  bresp_q;

  // ====================
  // Read path
  // ====================
  // One read in flight, AR closed until the response is taken
  assign s_arready    = !rd_pend_q && !s_rvalid;
  assign ar_hs        = s_arvalid && s_arready;
  assign bram_rd_en   = ar_hs;
  assign bram_rd_addr = s_araddr[NUM_NODE_ADDR_W+1:2];
  assign s_rresp      = rresp_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend_q <= 1'b0;
      s_rvalid  <= 1'b0;
    end else begin
      rd_pend_q <= ar_hs;
      if (rd_pend_q) begin
        s_rvalid <= 1'b1;
      end else if (s_rready) begin
        s_rvalid <= 1'b0;
      end
    end
  end

  // Stage 1 holds the decoded request while the RAM reads
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_sel_q <= decode_reg(s_araddr);
      rd_idx_q <= bram_rd_addr;
    end
  end

  always_comb begin
    rdata_d = '0;
    rresp_d = SLVERR;
    case (rd_sel_q)
      REG_STATUS: begin
        rdata_d[STATUS_MISMATCH_BIT]                     = count_mismatch;
        rdata_d[STATUS_COUNT_LSB +: SUBGRAPH_CNT_WIDTH] = subgraph_count;
        rresp_d                                          = OKAY;
      end
      REG_TABLE: begin
        // Only entries already written are valid
        if ({1'b0, rd_idx_q} < subgraph_count) begin
          rdata_d[NUM_NODE_WIDTH-1:0] = bram_rd_data;
          rresp_d                     = OKAY;
        end
      end
      default: ;
    endcase
  end

  // Stage 2, held while RREADY is low
  always_ff @(posedge clk) begin
    if (rd_pend_q) begin
      s_rdata <= rdata_d;
      rresp_q <= rresp_d;
    end
  end

  // ====================
  // Write path
  // ====================
  assign s_awready = !aw_got_q && !s_bvalid;
  assign s_wready  = !w_got_q && !s_bvalid;
  assign aw_hs     = s_awvalid && s_awready;
  assign w_hs      = s_wvalid && s_wready;
  assign wr_fire   = (aw_got_q || aw_hs) && (w_got_q || w_hs);
  assign wr_sel    = aw_got_q ? aw_sel_q : decode_reg(s_awaddr);
  assign wr_cmd    = w_got_q ? w_cmd_q : s_wdata[CLEAR_CMD_BIT];
  assign s_bresp   = bresp_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      s_bvalid <= 1'b0;
      clear    <= 1'b0;
    end else begin
      clear <= 1'b0;
      if (wr_fire) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        s_bvalid <= 1'b1;
        clear    <= (wr_sel == REG_CLEAR) && wr_cmd;
      end else begin
        if (aw_hs) aw_got_q <= 1'b1;
        if (w_hs) w_got_q <= 1'b1;
        if (s_bvalid && s_bready) s_bvalid <= 1'b0;
      end
    end
  end

  // Address and data may arrive in different cycles
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_sel_q <= decode_reg(s_awaddr);
    end
    if (w_hs) begin
      w_cmd_q <= s_wdata[CLEAR_CMD_BIT];
    end
    if (wr_fire) begin
      bresp_q <= (wr_sel == REG_CLEAR) ? OKAY : SLVERR;
    end
  end

endmodule

//--- rtl/num_node_bram.sv
/*
 * Node-count table RAM
 * Simple dual-port memory, port A writes and port B reads registered
 */
`timescale 1ns/1ns

module num_node_bram (
  input  logic                                       clk,
  input  logic                                       ena,
  input  logic [gat_types_pkg::NUM_NODE_ADDR_W-1:0]  addra,
  input  logic [gat_types_pkg::NUM_NODE_WIDTH-1:0]   dina,
  input  logic                                       enb,
  input  logic [gat_types_pkg::NUM_NODE_ADDR_W-1:0]  addrb,
  output logic [gat_types_pkg::NUM_NODE_WIDTH-1:0]   doutb
);
  import gat_types_pkg::*;

  logic [NUM_NODE_WIDTH-1:0] mem [NUM_SUBGRAPHS];

  // Port A
  always_ff @(posedge clk) begin
    if (ena) begin
      mem[addra] <= dina;
    end
  end

  // Port B, data one cycle after enb
  always_ff @(posedge clk) begin
    if (enb) begin
      doutb <= mem[addrb];
    end
  end

endmodule

//--- rtl/num_node_controller.sv
/*
 * Node-count controller
 * Writes one node count per subgraph into the table RAM at
 * consecutive addresses and keeps the saturating subgraph count
 */
`timescale 1ns/1ns

module num_node_controller (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          spmm_vld,
  input  logic                                          src_flag,
  input  logic [gat_types_pkg::NUM_NODE_WIDTH-1:0]      num_node,
  input  logic                                          clear,
  output logic [gat_types_pkg::NUM_NODE_WIDTH-1:0]      num_node_bram_din,
  output logic                                          num_node_bram_ena,
  output logic [gat_types_pkg::NUM_NODE_ADDR_W-1:0]     num_node_bram_addra,
  output logic [gat_types_pkg::SUBGRAPH_CNT_WIDTH-1:0]  subgraph_count
);
  import gat_types_pkg::*;
  import gat_ctrl_pkg::*;

  num_node_state_e               state_q;
  num_node_state_e               state_d;
  logic [SUBGRAPH_CNT_WIDTH-1:0] addr_q;
  logic [NUM_NODE_WIDTH-1:0]     din_q;
  logic                          src_word;
  logic                          table_full;

  assign src_word   = spmm_vld && src_flag;
  assign table_full = (addr_q == SUBGRAPH_CNT_WIDTH'(NUM_SUBGRAPHS));

  // ====================
  // Table write
  // ====================
  assign num_node_bram_din   = din_q;
  assign num_node_bram_ena   = (state_q == RUN) && !table_full;
  assign num_node_bram_addra = addr_q[NUM_NODE_ADDR_W-1:0];
  assign subgraph_count      = addr_q;

  // ====================
  // State machine
  // ====================
  // A source word in RUN starts the next subgraph at once
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (src_word) state_d = RUN;
      RUN:  state_d = src_word ? RUN : DONE;
      DONE: begin
        if (src_word) begin
          state_d = RUN;
        end else if (spmm_vld) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else if (clear) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == RUN && !table_full) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // Count captured with the source word
  always_ff @(posedge clk) begin
    if (src_word) begin
      din_q <= num_node;
    end
  end

endmodule

//--- rtl/node_info_decoder.sv
/*
 * Node-info decoder
 * Accepts node-info words, registers their fields for the controller
 * and checks each subgraph's announced node count against its words
 */
`timescale 1ns/1ns

module node_info_decoder (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       node_info_valid,
  input  logic [gat_types_pkg::NODE_INFO_WIDTH-1:0]  node_info_data,
  output logic                                       node_info_ready,
  input  logic                                       clear,
  output logic                                       spmm_vld,
  output logic                                       src_flag,
  output logic [gat_types_pkg::NUM_NODE_WIDTH-1:0]   num_node,
  output logic                                       count_mismatch
);
  import gat_types_pkg::*;

  logic                      accept;
  logic                      word_src;
  logic [NUM_NODE_WIDTH-1:0] word_num_node;
  logic [WORD_CNT_WIDTH-1:0] word_cnt;
  logic [NUM_NODE_WIDTH-1:0] expected_q;

  assign accept        = node_info_valid && node_info_ready;
  assign word_src      = node_info_data[SRC_FLAG_POS];
  assign word_num_node = node_info_data[NUM_NODE_LSB +: NUM_NODE_WIDTH];

  // ====================
  // Handshake
  // ====================
  // Ready drops for one cycle after a clear to flush the pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_info_ready <= 1'b1;
      spmm_vld        <= 1'b0;
    end else begin
      node_info_ready <= !clear;
      spmm_vld        <= accept && !clear;
    end
  end

  // Fields of the last accepted word
  always_ff @(posedge clk) begin
    if (accept) begin
      src_flag <= word_src;
      num_node <= word_num_node;
    end
  end

  // ====================
  // Node count check
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt       <= '0;
      expected_q     <= '0;
      count_mismatch <= 1'b0;
    end else if (clear) begin
      word_cnt       <= '0;
      expected_q     <= '0;
      count_mismatch <= 1'b0;
    end else if (accept) begin
      if (word_src) begin
        // Close the previous subgraph, if any, and open a new one
        if (word_cnt != '0 && word_cnt != {1'b0, expected_q}) begin
          count_mismatch <= 1'b1;
        end
        word_cnt   <= WORD_CNT_WIDTH'(1);
        expected_q <= word_num_node;
      end else if (word_cnt != '1) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

endmodule

//--- rtl/gat_ctrl_pkg.sv
/*
 * GAT node-count control definitions
 * Controller states, AXI4-Lite register map and response codes
 */
package gat_ctrl_pkg;

  localparam int AXI_ADDR_WIDTH = 12;
  localparam int AXI_DATA_WIDTH = 32;

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    RUN  = 2'b01,
    DONE = 2'b10
  } num_node_state_e;

  typedef enum logic [1:0] {
    REG_STATUS,
    REG_CLEAR,
    REG_TABLE,
    REG_NONE
  } reg_sel_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // ====================
  // Register map
  // ====================
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS_ADDR = 12'h000;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_CLEAR_ADDR  = 12'h004;
  localparam logic [AXI_ADDR_WIDTH-1:0] TABLE_BASE_ADDR = 12'h100;

  // Status word fields
  localparam int STATUS_MISMATCH_BIT = 0;
  localparam int STATUS_COUNT_LSB    = 8;

  // Clear register command bit
  localparam int CLEAR_CMD_BIT = 0;

  // Table spans 0x100..0x1FC, word aligned
  function automatic reg_sel_e decode_reg(input logic [AXI_ADDR_WIDTH-1:0] addr);
    reg_sel_e sel;
    if (addr == REG_STATUS_ADDR) begin
      sel = REG_STATUS;
    end else if (addr == REG_CLEAR_ADDR) begin
      sel = REG_CLEAR;
    end else if (addr[11:8] == TABLE_BASE_ADDR[11:8] && addr[1:0] == 2'b00) begin
      sel = REG_TABLE;
    end else begin
      sel = REG_NONE;
    end
    return sel;
  endfunction

endpackage

//--- rtl/gat_types_pkg.sv
/*
 * GAT node-count subsystem types
 * Subgraph table sizes and the bit layout of node-info words
 */
package gat_types_pkg;

  // ====================
  // Table sizes
  // ====================
  localparam int MAX_NODES          = 16;
  localparam int NUM_SUBGRAPHS      = 64;
  localparam int NUM_NODE_WIDTH     = $clog2(MAX_NODES + 1);
  localparam int NUM_NODE_ADDR_W    = $clog2(NUM_SUBGRAPHS);

  // One extra bit so the count can reach NUM_SUBGRAPHS
  localparam int SUBGRAPH_CNT_WIDTH = NUM_NODE_ADDR_W + 1;

  // ====================
  // Node-info word
  // ====================
  // Layout from the LSB: source flag, node count, row length
  localparam int ROW_LEN_WIDTH      = 11;
  localparam int SRC_FLAG_POS       = 0;
  localparam int NUM_NODE_LSB       = SRC_FLAG_POS + 1;
  localparam int ROW_LEN_LSB        = NUM_NODE_LSB + NUM_NODE_WIDTH;
  localparam int NODE_INFO_WIDTH    = ROW_LEN_LSB + ROW_LEN_WIDTH;

  // Words seen in one subgraph, spare bit for oversize subgraphs
  localparam int WORD_CNT_WIDTH     = NUM_NODE_WIDTH + 1;

endpackage
